// ==== icache_pkg.sv ====
// instruction cache definitions

package icache_pkg;

  // ====================================================================
  // geometry
  // ====================================================================
  localparam int addr_w         = 32;
  localparam int way_num        = 2;
  localparam int line_bytes     = 16;
  localparam int words_per_line = 4;
  localparam int idx_w          = 4;
  localparam int ofs_w          = 4;
  localparam int tag_w          = 24;

  // ====================================================================
  // address views
  // ====================================================================
  // word selects the instruction inside a line, boff is the byte lane
  typedef struct packed {
    logic [tag_w-1:0]                          tag;
    logic [idx_w-1:0]                          idx;
    logic [$clog2(words_per_line)-1:0]         word;
    logic [ofs_w-$clog2(words_per_line)-1:0]   boff;
  } icache_addr_s;

  typedef union packed {
    logic [addr_w-1:0] raw;
    icache_addr_s      f;
  } icache_addr_u;

  // refill engine states, also watched by the lookup pipeline
  typedef enum logic [1:0] {
    refill_idle,
    refill_req,
    refill_collect
  } refill_state_e;

endpackage

// ==== mem_rd_if.sv ====
// burst read channel

`timescale 1ns/1ps

interface mem_rd_if;

  // address phase
  logic                          ar_valid;
  logic [icache_pkg::addr_w-1:0] ar_addr;
  logic                          ar_ready;

  // data beats
  logic                          r_valid;
  logic [31:0]                   r_data;
  logic                          r_last;
  logic                          r_ready;

  modport master (
    output ar_valid, ar_addr, r_ready,
    input  ar_ready, r_valid, r_data, r_last
  );

  modport slave (
    input  ar_valid, ar_addr, r_ready,
    output ar_ready, r_valid, r_data, r_last
  );

endinterface

// ==== sdp_ram.sv ====
// simple dual-port RAM

`timescale 1ns/1ps

module sdp_ram #(
  parameter int depth = 16,
  parameter int width = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(depth)-1:0] waddr_i,
  input  logic [width-1:0]         wdata_i,
  input  logic [$clog2(depth)-1:0] raddr_i,
  output logic [width-1:0]         rdata_o
);

  logic [width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    // write-first on an address collision
    if (we_i && waddr_i == raddr_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// ==== icache_refill.sv ====
// instruction cache refill engine

`timescale 1ns/1ps

module icache_refill (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   miss_req_i,
  input  icache_pkg::icache_addr_u               miss_addr_i,
  output logic                                   refill_done_o,
  output logic [icache_pkg::line_bytes*8-1:0]    refill_line_o,
  output icache_pkg::refill_state_e              refill_state_o,
  mem_rd_if.master                               mem
);

  icache_pkg::refill_state_e                                state_q;
  icache_pkg::icache_addr_u                                 burst_addr_q;
  logic [$clog2(icache_pkg::words_per_line)-1:0]            beat_cnt_q;
  logic [icache_pkg::words_per_line-1:0][31:0]              line_q;
  logic                                                     done_q;

  // ====================================================================
  // state machine
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= icache_pkg::refill_idle;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        icache_pkg::refill_idle: begin
          if (miss_req_i) begin
            state_q    <= icache_pkg::refill_req;
            beat_cnt_q <= '0;
          end
        end
        icache_pkg::refill_req: begin
          if (mem.ar_ready) begin
            state_q <= icache_pkg::refill_collect;
          end
        end
        icache_pkg::refill_collect: begin
          if (mem.r_valid) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (mem.r_last) begin
              state_q <= icache_pkg::refill_idle;
              done_q  <= 1'b1;
            end
          end
        end
        default: state_q <= icache_pkg::refill_idle;
      endcase
    end
  end

  // burst address and line buffer
  always_ff @(posedge clk) begin
    if (state_q == icache_pkg::refill_idle && miss_req_i) begin
      burst_addr_q        <= miss_addr_i;
      // whole line, starting at word 0
      burst_addr_q.f.word <= '0;
      burst_addr_q.f.boff <= '0;
    end
    if (state_q == icache_pkg::refill_collect && mem.r_valid) begin
      line_q[beat_cnt_q] <= mem.r_data;
    end
  end

  assign mem.ar_valid   = state_q == icache_pkg::refill_req;
  assign mem.ar_addr    = burst_addr_q.raw;
  assign mem.r_ready    = state_q == icache_pkg::refill_collect;

  assign refill_done_o  = done_q;
  assign refill_line_o  = line_q;
  assign refill_state_o = state_q;

endmodule

// ==== icache_core.sv ====
// instruction cache lookup pipeline

`timescale 1ns/1ps

module icache_core (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                flush_i,
  // fetch request
  input  logic                                fetch_valid_i,
  input  logic [icache_pkg::addr_w-1:0]       fetch_addr_i,
  output logic                                fetch_ready_o,
  // fetch response
  output logic                                rsp_valid_o,
  output logic [31:0]                         rsp_instr_o,
  output logic                                rsp_fault_o,
  input  logic                                rsp_ready_i,
  // refill engine
  output logic                                miss_req_o,
  output icache_pkg::icache_addr_u            miss_addr_o,
  input  logic                                refill_done_i,
  input  logic [icache_pkg::line_bytes*8-1:0] refill_line_i,
  input  icache_pkg::refill_state_e           refill_state_i
);

  icache_pkg::icache_addr_u s0_addr;
  icache_pkg::icache_addr_u s1_addr;
  logic                     s0_fault;
  logic                     s1_valid;
  logic                     s1_fault;
  logic                     s1_served;
  logic                     s1_advance;

  logic [icache_pkg::idx_w-1:0]                                 ram_raddr;
  logic [icache_pkg::way_num-1:0]                               way_we;
  logic [icache_pkg::way_num-1:0][icache_pkg::tag_w-1:0]        tag_rdata;
  logic [icache_pkg::way_num-1:0][icache_pkg::line_bytes*8-1:0] data_rdata;

  // per set: valid bit per way, most recently used way
  logic [2**icache_pkg::idx_w-1:0][icache_pkg::way_num-1:0]           valid_q;
  logic [2**icache_pkg::idx_w-1:0][$clog2(icache_pkg::way_num)-1:0]   mru_q;

  logic [icache_pkg::way_num-1:0]          hit_vec;
  logic                                    hit;
  logic [$clog2(icache_pkg::way_num)-1:0]  hit_way;
  logic [$clog2(icache_pkg::way_num)-1:0]  victim_way;
  logic                                    refill_drop;
  logic                                    refill_ok;
  logic                                    refill_wr;
  logic [icache_pkg::line_bytes*8-1:0]     rsp_line;

  // ====================================================================
  // stage 0
  // ====================================================================
  assign s0_addr.raw = fetch_addr_i;
  // misaligned fetch goes down as a fault, never as a miss
  assign s0_fault    = s0_addr.f.boff != '0;

  assign s1_advance    = !s1_valid || (rsp_valid_o && rsp_ready_i);
  assign fetch_ready_o = s1_advance;

  // held fetch keeps reading its own set
  assign ram_raddr = s1_advance ? s0_addr.f.idx : s1_addr.f.idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_fault  <= 1'b0;
      s1_served <= 1'b0;
    end else if (flush_i) begin
      s1_valid  <= 1'b0;
      s1_served <= 1'b0;
    end else if (s1_advance) begin
      s1_valid  <= fetch_valid_i;
      s1_fault  <= s0_fault;
      s1_served <= 1'b0;
    end else if (refill_ok) begin
      s1_served <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_advance) begin
      s1_addr <= s0_addr;
    end
  end

  // ====================================================================
  // stage 1
  // ====================================================================
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < icache_pkg::way_num; w++) begin
      hit_vec[w] = valid_q[s1_addr.f.idx][w] && tag_rdata[w] == s1_addr.f.tag;
      if (hit_vec[w]) begin
        hit_way = ($clog2(icache_pkg::way_num))'(w);
      end
    end
  end

  assign hit        = s1_valid && !s1_fault && |hit_vec;
  assign victim_way = ~mru_q[s1_addr.f.idx];

  // line from a refill that was started before a flush is thrown away
  assign refill_ok = refill_done_i && !refill_drop;
  assign refill_wr = refill_ok && s1_valid && !flush_i;

  assign rsp_valid_o = s1_valid && (s1_fault || hit || s1_served || refill_ok);
  assign rsp_fault_o = s1_fault;
  assign rsp_line    = (s1_served || refill_ok) ? refill_line_i : data_rdata[hit_way];
  assign rsp_instr_o = s1_fault ? '0 : rsp_line[s1_addr.f.word*32 +: 32];

  assign miss_req_o  = s1_valid && !s1_fault && !hit && !s1_served && !refill_done_i &&
                       refill_state_i == icache_pkg::refill_idle && !flush_i;
  assign miss_addr_o = s1_addr;

  // valid bits, pseudo-LRU and stale refill tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= '0;
      mru_q       <= '0;
      refill_drop <= 1'b0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end else if (refill_wr) begin
        valid_q[s1_addr.f.idx][victim_way] <= 1'b1;
      end

      if (refill_wr) begin
        mru_q[s1_addr.f.idx] <= victim_way;
      end else if (hit) begin
        mru_q[s1_addr.f.idx] <= hit_way;
      end

      if (flush_i && refill_state_i != icache_pkg::refill_idle) begin
        refill_drop <= 1'b1;
      end else if (refill_done_i) begin
        refill_drop <= 1'b0;
      end
    end
  end

  // ====================================================================
  // tag and data arrays
  // ====================================================================
  for (genvar w = 0; w < icache_pkg::way_num; w++) begin : g_way
    assign way_we[w] = refill_wr && victim_way == ($clog2(icache_pkg::way_num))'(w);

    sdp_ram #(
      .depth (2**icache_pkg::idx_w),
      .width (icache_pkg::tag_w)
    ) tag_ram_i (
      .clk     (clk),
      .we_i    (way_we[w]),
      .waddr_i (s1_addr.f.idx),
      .wdata_i (s1_addr.f.tag),
      .raddr_i (ram_raddr),
      .rdata_o (tag_rdata[w])
    );

    sdp_ram #(
      .depth (2**icache_pkg::idx_w),
      .width (icache_pkg::line_bytes*8)
    ) data_ram_i (
      .clk     (clk),
      .we_i    (way_we[w]),
      .waddr_i (s1_addr.f.idx),
      .wdata_i (refill_line_i),
      .raddr_i (ram_raddr),
      .rdata_o (data_rdata[w])
    );
  end

endmodule

// ==== icache_top.sv ====
// instruction cache top level

`timescale 1ns/1ps

module icache_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  // fetch side
  input  logic                          fetch_valid_i,
  input  logic [icache_pkg::addr_w-1:0] fetch_addr_i,
  output logic                          fetch_ready_o,
  output logic                          rsp_valid_o,
  output logic [31:0]                   rsp_instr_o,
  output logic                          rsp_fault_o,
  input  logic                          rsp_ready_i,
  // memory read channel
  output logic                          mem_ar_valid_o,
  output logic [icache_pkg::addr_w-1:0] mem_ar_addr_o,
  input  logic                          mem_ar_ready_i,
  input  logic                          mem_r_valid_i,
  input  logic [31:0]                   mem_r_data_i,
  input  logic                          mem_r_last_i,
  output logic                          mem_r_ready_o
);

  logic                                miss_req;
  icache_pkg::icache_addr_u            miss_addr;
  logic                                refill_done;
  logic [icache_pkg::line_bytes*8-1:0] refill_line;
  icache_pkg::refill_state_e           refill_state;

  mem_rd_if mem_bus ();

  // ====================================================================
  // bus pins
  // ====================================================================
  assign mem_ar_valid_o   = mem_bus.ar_valid;
  assign mem_ar_addr_o    = mem_bus.ar_addr;
  assign mem_r_ready_o    = mem_bus.r_ready;
  assign mem_bus.ar_ready = mem_ar_ready_i;
  assign mem_bus.r_valid  = mem_r_valid_i;
  assign mem_bus.r_data   = mem_r_data_i;
  assign mem_bus.r_last   = mem_r_last_i;

  icache_core icache_core_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_instr_o    (rsp_instr_o),
    .rsp_fault_o    (rsp_fault_o),
    .rsp_ready_i    (rsp_ready_i),
    .miss_req_o     (miss_req),
    .miss_addr_o    (miss_addr),
    .refill_done_i  (refill_done),
    .refill_line_i  (refill_line),
    .refill_state_i (refill_state)
  );

  icache_refill icache_refill_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss_req_i     (miss_req),
    .miss_addr_i    (miss_addr),
    .refill_done_o  (refill_done),
    .refill_line_o  (refill_line),
    .refill_state_o (refill_state),
    .mem            (mem_bus.master)
  );

endmodule

// ==== icache_properties.sv ====
// fetch and memory handshake checks

`timescale 1ns/1ps

module icache_properties (
  input logic        clk,
  input logic        rst_n,
  input logic        flush_i,
  input logic        rsp_valid_i,
  input logic        rsp_ready_i,
  input logic [31:0] rsp_instr_i,
  input logic        rsp_fault_i,
  input logic        mem_ar_valid_i,
  input logic        mem_ar_ready_i,
  input logic [31:0] mem_ar_addr_i,
  input logic        mem_r_valid_i,
  input logic        mem_r_last_i,
  input logic        mem_r_ready_i
);

  logic burst_open;

  // open from address accept until the last beat is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      burst_open <= 1'b0;
    end else if (mem_ar_valid_i && mem_ar_ready_i) begin
      burst_open <= 1'b1;
    end else if (mem_r_valid_i && mem_r_ready_i && mem_r_last_i) begin
      burst_open <= 1'b0;
    end
  end

  // burst request waits with a fixed address
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ar_valid_i && !mem_ar_ready_i |=> mem_ar_valid_i && $stable(mem_ar_addr_i))
    else $error("burst address changed before it was accepted");

  // stalled response, a flush may still drop it
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_i && !rsp_ready_i && !flush_i
    |=> rsp_valid_i && $stable(rsp_instr_i) && $stable(rsp_fault_i))
    else $error("response changed while the consumer stalled");

  // one burst on the bus at a time
  no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_ar_valid_i && (mem_r_ready_i || burst_open)))
    else $error("new burst requested while beats were collected");

endmodule

bind icache_top icache_properties icache_properties_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .flush_i        (flush_i),
  .rsp_valid_i    (rsp_valid_o),
  .rsp_ready_i    (rsp_ready_i),
  .rsp_instr_i    (rsp_instr_o),
  .rsp_fault_i    (rsp_fault_o),
  .mem_ar_valid_i (mem_ar_valid_o),
  .mem_ar_ready_i (mem_ar_ready_i),
  .mem_ar_addr_i  (mem_ar_addr_o),
  .mem_r_valid_i  (mem_r_valid_i),
  .mem_r_last_i   (mem_r_last_i),
  .mem_r_ready_i  (mem_r_ready_o)
);

// ==== tb_icache.sv ====
// instruction cache testbench

`timescale 1ns/1ps

module tb_icache;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        flush_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_addr_i;
  logic        fetch_ready_o;
  logic        rsp_valid_o;
  logic [31:0] rsp_instr_o;
  logic        rsp_fault_o;
  logic        rsp_ready_i;
  logic        mem_ar_valid_o;
  logic [31:0] mem_ar_addr_o;
  logic        mem_ar_ready_i;
  logic        mem_r_valid_i;
  logic [31:0] mem_r_data_i;
  logic        mem_r_last_i;
  logic        mem_r_ready_o;

  int errors = 0;
  int bursts = 0;

  // stimulus table, one column per queue
  string       t_name[$];
  logic [31:0] t_addr[$];
  bit          t_flush[$];
  int          t_hold[$];
  int          t_bursts[$];
  bit          t_fault[$];

  always #2 clk = ~clk;

  icache_top icache_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_instr_o    (rsp_instr_o),
    .rsp_fault_o    (rsp_fault_o),
    .rsp_ready_i    (rsp_ready_i),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_last_i   (mem_r_last_i),
    .mem_r_ready_o  (mem_r_ready_o)
  );

  // ====================================================================
  // memory model
  // ====================================================================
  // word at address A reads as A ^ 5a5a0000, four beats per burst
  initial begin : memory_model
    logic [31:0] base;
    int unsigned gap;
    void'($urandom(32'h1e7f8908));
    forever begin
      @(negedge clk);
      if (rst_n && mem_ar_valid_o) begin
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge clk);
        base           = mem_ar_addr_o;
        mem_ar_ready_i = 1'b1;
        @(negedge clk);
        mem_ar_ready_i = 1'b0;
        bursts++;
        for (int b = 0; b < 4; b++) begin
          mem_r_valid_i = 1'b1;
          mem_r_data_i  = (base + 32'(4 * b)) ^ 32'h5a5a0000;
          mem_r_last_i  = b == 3;
          // beat stays on the bus until the cache takes it
          while (!mem_r_ready_o) begin
            @(negedge clk);
          end
          @(negedge clk);
        end
        mem_r_valid_i = 1'b0;
        mem_r_last_i  = 1'b0;
      end
    end
  end

  task automatic add_test(input string name, input logic [31:0] addr, input bit flush,
                          input int hold, input int nb, input bit fault);
    t_name.push_back(name);
    t_addr.push_back(addr);
    t_flush.push_back(flush);
    t_hold.push_back(hold);
    t_bursts.push_back(nb);
    t_fault.push_back(fault);
  endtask

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
      errors++;
    end
  endtask

  // one table row: optional flush, one fetch, optional back-pressure
  task automatic run_test(input int t);
    int          fails_before;
    int          bursts_before;
    logic [31:0] expected_instr;
    fails_before   = errors;
    bursts_before  = bursts;
    expected_instr = t_addr[t] ^ 32'h5a5a0000;
    if (t_flush[t]) begin
      flush_i = 1'b1;
      @(negedge clk);
      flush_i = 1'b0;
    end
    rsp_ready_i = t_hold[t] == 0;
    compare({t_name[t], " fetch_ready"}, 32'd1, 32'(fetch_ready_o));
    fetch_valid_i = 1'b1;
    fetch_addr_i  = t_addr[t];
    @(negedge clk);
    fetch_valid_i = 1'b0;
    for (int c = 0; c < 30 && !rsp_valid_o; c++) begin
      @(negedge clk);
    end
    if (!rsp_valid_o) begin
      $display("test %s: the DUT gave no response within 30 cycles", t_name[t]);
      errors++;
    end
    compare({t_name[t], " fault"}, 32'(t_fault[t]), 32'(rsp_fault_o));
    if (!t_fault[t]) begin
      compare({t_name[t], " instr"}, expected_instr, rsp_instr_o);
    end
    // response has to sit still while the consumer stalls
    repeat (t_hold[t]) begin
      @(negedge clk);
      compare({t_name[t], " held valid"}, 32'd1, 32'(rsp_valid_o));
      compare({t_name[t], " held fetch_ready"}, 32'd0, 32'(fetch_ready_o));
      if (!t_fault[t]) begin
        compare({t_name[t], " held instr"}, expected_instr, rsp_instr_o);
      end
    end
    rsp_ready_i = 1'b1;
    @(negedge clk);
    compare({t_name[t], " bursts"}, 32'(t_bursts[t]), 32'(bursts - bursts_before));
    $display("test %-16s %s", t_name[t], errors == fails_before ? "passed" : "failed");
  endtask

  initial begin : main
    rst_n          = 1'b0;
    flush_i        = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_addr_i   = '0;
    rsp_ready_i    = 1'b1;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    mem_r_last_i   = 1'b0;

    //       name             address       flush hold bursts fault
    add_test("cold_miss",     32'h00000100, 1'b0, 0, 1, 1'b0);
    add_test("same_line",     32'h0000010c, 1'b0, 0, 0, 1'b0);
    add_test("repeat_hit_0",  32'h00000100, 1'b0, 0, 0, 1'b0);
    add_test("repeat_hit_1",  32'h00000100, 1'b0, 0, 0, 1'b0);
    // A, B, A, C in set 5, then B is the evicted line
    add_test("lru_a",         32'h00001050, 1'b0, 0, 1, 1'b0);
    add_test("lru_b",         32'h00002050, 1'b0, 0, 1, 1'b0);
    add_test("lru_a_hit",     32'h00001054, 1'b0, 0, 0, 1'b0);
    add_test("lru_c",         32'h00003050, 1'b0, 0, 1, 1'b0);
    add_test("lru_a_kept",    32'h00001058, 1'b0, 0, 0, 1'b0);
    add_test("lru_b_evicted", 32'h0000205c, 1'b0, 0, 1, 1'b0);
    add_test("hold_hit",      32'h00000104, 1'b0, 5, 0, 1'b0);
    add_test("after_hold",    32'h00000108, 1'b0, 0, 0, 1'b0);
    add_test("hold_miss",     32'h00000200, 1'b0, 4, 1, 1'b0);
    add_test("flush_refetch", 32'h00000100, 1'b1, 0, 1, 1'b0);
    add_test("misaligned_0",  32'h00000102, 1'b0, 0, 0, 1'b1);
    add_test("misaligned_1",  32'h00000203, 1'b0, 0, 0, 1'b1);

    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int t = 0; t < t_name.size(); t++) begin
      run_test(t);
    end
    $display("tests run: %0d, failed checks: %0d, bursts: %0d", t_name.size(), errors, bursts);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // budget of 40 cycles per table row
  initial begin : watchdog
    #1;
    repeat (t_name.size() * 40) @(posedge clk);
    $display("watchdog: the tests did not finish within %0d cycles", t_name.size() * 40);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== files.f ====
icache_pkg.sv
mem_rd_if.sv
sdp_ram.sv
icache_refill.sv
icache_core.sv
icache_top.sv
icache_properties.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_icache
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
